//--- common/mem_pkg.sv
package mem_pkg;

    // Memory side bus widths
    localparam int ADDR_W = 64;
    localparam int DATA_W = 64;
    localparam int STRB_W = DATA_W / 8;

    // Fetch addresses are zero-extended to ADDR_W at the arbiter
    localparam int FETCH_ADDR_W = 32;

    // Response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // Read address
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
    } ar_req_t;

    // Write address
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
    } aw_req_t;

    // Write data with byte strobes
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
    } w_req_t;

    // Read response
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [1:0]        resp;
    } r_rsp_t;

    // Write response
    typedef struct packed {
        logic [1:0] resp;
    } b_rsp_t;

endpackage

//--- hdl/axi_chan_reg.sv
`timescale 1ns/1ps

module axi_chan_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,

    input  logic     in_valid_i,
    output logic     in_ready_o,
    input  payload_t in_data_i,

    output logic     out_valid_o,
    input  logic     out_ready_i,
    output payload_t out_data_o
);

    logic     out_valid_q;
    logic     skid_valid_q;
    payload_t out_data_q;
    payload_t skid_data_q;
    logic     in_fire;
    logic     out_free;

    // Ready only looks at the skid slot, so no path from out_ready_i
    assign in_ready_o = ~skid_valid_q;
    assign in_fire    = in_valid_i & in_ready_o;
    assign out_free   = ~out_valid_q | out_ready_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_q  <= 1'b0;
            skid_valid_q <= 1'b0;
        end else if (out_free) begin
            if (skid_valid_q) begin
                out_valid_q  <= 1'b1;
                skid_valid_q <= 1'b0;
            end else begin
                out_valid_q <= in_fire;
            end
        end else if (in_fire) begin
            // Output stalled, park the new item
            skid_valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (out_free) begin
            if (skid_valid_q) begin
                out_data_q <= skid_data_q;
            end else if (in_fire) begin
                out_data_q <= in_data_i;
            end
        end else if (in_fire) begin
            skid_data_q <= in_data_i;
        end
    end

    assign out_valid_o = out_valid_q;
    assign out_data_o  = out_data_q;

    a_out_stable: assert property (@(posedge clk) disable iff (rst)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o));

endmodule

//--- arbiter/axi_arbiter.sv
`timescale 1ns/1ps

module axi_arbiter (
    input  logic                              clk,
    input  logic                              rst,

    // Fetch port, read only
    input  logic                              f_ar_valid_i,
    output logic                              f_ar_ready_o,
    input  logic [mem_pkg::FETCH_ADDR_W-1:0]  f_ar_addr_i,
    output logic                              f_r_valid_o,
    input  logic                              f_r_ready_i,
    output mem_pkg::r_rsp_t                   f_r_o,

    // Load/store port
    input  logic                              l_ar_valid_i,
    output logic                              l_ar_ready_o,
    input  mem_pkg::ar_req_t                  l_ar_i,
    input  logic                              l_aw_valid_i,
    output logic                              l_aw_ready_o,
    input  mem_pkg::aw_req_t                  l_aw_i,
    input  logic                              l_w_valid_i,
    output logic                              l_w_ready_o,
    input  mem_pkg::w_req_t                   l_w_i,
    output logic                              l_r_valid_o,
    input  logic                              l_r_ready_i,
    output mem_pkg::r_rsp_t                   l_r_o,
    output logic                              l_b_valid_o,
    input  logic                              l_b_ready_i,
    output mem_pkg::b_rsp_t                   l_b_o,

    // Memory side
    output logic                              m_ar_valid_o,
    input  logic                              m_ar_ready_i,
    output mem_pkg::ar_req_t                  m_ar_o,
    output logic                              m_aw_valid_o,
    input  logic                              m_aw_ready_i,
    output mem_pkg::aw_req_t                  m_aw_o,
    output logic                              m_w_valid_o,
    input  logic                              m_w_ready_i,
    output mem_pkg::w_req_t                   m_w_o,
    input  logic                              m_r_valid_i,
    output logic                              m_r_ready_o,
    input  mem_pkg::r_rsp_t                   m_r_i,
    input  logic                              m_b_valid_i,
    output logic                              m_b_ready_o,
    input  mem_pkg::b_rsp_t                   m_b_i
);

    typedef enum logic [1:0] {
        GNT_IDLE  = 2'd0,
        GNT_FETCH = 2'd1,
        GNT_LSU   = 2'd2
    } grant_t;

    grant_t grant_q;
    grant_t grant_d;
    logic   ar_done_q;
    logic   gnt_fetch;
    logic   gnt_lsu;
    logic   m_ar_fire;
    logic   m_r_fire;

    assign gnt_fetch = (grant_q == GNT_FETCH);
    assign gnt_lsu   = (grant_q == GNT_LSU);
    assign m_ar_fire = m_ar_valid_o & m_ar_ready_i;
    assign m_r_fire  = m_r_valid_i & m_r_ready_o;

    // Load/store wins when both ask in the same cycle
    always_comb begin
        grant_d = grant_q;
        case (grant_q)
            GNT_IDLE: begin
                if (l_ar_valid_i) begin
                    grant_d = GNT_LSU;
                end else if (f_ar_valid_i) begin
                    grant_d = GNT_FETCH;
                end
            end
            GNT_FETCH, GNT_LSU: begin
                if (m_r_fire) begin
                    grant_d = GNT_IDLE;
                end
            end
            default: grant_d = GNT_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            grant_q   <= GNT_IDLE;
            ar_done_q <= 1'b0;
        end else begin
            grant_q <= grant_d;
            // One address per grant
            if (m_r_fire) begin
                ar_done_q <= 1'b0;
            end else if (m_ar_fire) begin
                ar_done_q <= 1'b1;
            end
        end
    end

    // Read address, only the granted port is forwarded
    always_comb begin
        m_ar_valid_o = 1'b0;
        m_ar_o       = '0;
        if (gnt_lsu) begin
            m_ar_valid_o = l_ar_valid_i & ~ar_done_q;
            m_ar_o       = l_ar_i;
        end else if (gnt_fetch) begin
            m_ar_valid_o = f_ar_valid_i & ~ar_done_q;
            m_ar_o.addr  = {{(mem_pkg::ADDR_W - mem_pkg::FETCH_ADDR_W){1'b0}}, f_ar_addr_i};
        end
    end

    assign l_ar_ready_o = gnt_lsu & ~ar_done_q & m_ar_ready_i;
    assign f_ar_ready_o = gnt_fetch & ~ar_done_q & m_ar_ready_i;

    // Read response steering
    assign m_r_ready_o = (gnt_lsu & l_r_ready_i) | (gnt_fetch & f_r_ready_i);
    assign l_r_valid_o = gnt_lsu & m_r_valid_i;
    assign f_r_valid_o = gnt_fetch & m_r_valid_i;
    assign l_r_o       = gnt_lsu ? m_r_i : '0;
    assign f_r_o       = gnt_fetch ? m_r_i : '0;

    // Writes only come from load/store
    assign m_aw_valid_o = l_aw_valid_i;
    assign m_aw_o       = l_aw_i;
    assign l_aw_ready_o = m_aw_ready_i;
    assign m_w_valid_o  = l_w_valid_i;
    assign m_w_o        = l_w_i;
    assign l_w_ready_o  = m_w_ready_i;
    assign l_b_valid_o  = m_b_valid_i;
    assign l_b_o        = m_b_i;
    assign m_b_ready_o  = l_b_ready_i;

    a_grant_locked: assert property (@(posedge clk) disable iff (rst)
        m_r_valid_i && !m_r_ready_o |=> grant_q == $past(grant_q));

    // Memory never answers a read that nobody owns
    a_idle_no_rsp: assert property (@(posedge clk) disable iff (rst)
        grant_q == GNT_IDLE |-> !m_r_valid_i);

endmodule

//--- sram/axi_sram.sv
`timescale 1ns/1ps

module axi_sram #(
    parameter int MEM_WORDS = 256
) (
    input  logic             clk,
    input  logic             rst,

    input  logic             ar_valid_i,
    output logic             ar_ready_o,
    input  mem_pkg::ar_req_t ar_i,

    input  logic             aw_valid_i,
    output logic             aw_ready_o,
    input  mem_pkg::aw_req_t aw_i,

    input  logic             w_valid_i,
    output logic             w_ready_o,
    input  mem_pkg::w_req_t  w_i,

    output logic             r_valid_o,
    input  logic             r_ready_i,
    output mem_pkg::r_rsp_t  r_o,

    output logic             b_valid_o,
    input  logic             b_ready_i,
    output mem_pkg::b_rsp_t  b_o
);

    localparam int IDX_W = $clog2(MEM_WORDS);
    localparam int OFF_W = $clog2(mem_pkg::STRB_W);

    logic [mem_pkg::DATA_W-1:0] mem_q [MEM_WORDS];

    logic                         r_valid_q;
    mem_pkg::r_rsp_t              r_rsp_q;
    logic                         b_valid_q;
    mem_pkg::b_rsp_t              b_rsp_q;
    logic                         ar_fire;
    logic                         wr_fire;
    logic [mem_pkg::ADDR_W-OFF_W-1:0] rd_word;
    logic [mem_pkg::ADDR_W-OFF_W-1:0] wr_word;
    logic                         rd_in_range;
    logic                         wr_in_range;

    assign rd_word     = ar_i.addr[mem_pkg::ADDR_W-1:OFF_W];
    assign wr_word     = aw_i.addr[mem_pkg::ADDR_W-1:OFF_W];
    assign rd_in_range = rd_word < MEM_WORDS;
    assign wr_in_range = wr_word < MEM_WORDS;

    // One read response slot
    assign ar_ready_o = ~r_valid_q;
    assign ar_fire    = ar_valid_i & ar_ready_o;

    // AW and W are taken together
    assign aw_ready_o = w_valid_i & ~b_valid_q;
    assign w_ready_o  = aw_valid_i & ~b_valid_q;
    assign wr_fire    = aw_valid_i & w_valid_i & ~b_valid_q;

    // Power-up contents are zero
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_q[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire && wr_in_range) begin
            for (int b = 0; b < mem_pkg::STRB_W; b++) begin
                if (w_i.strb[b]) begin
                    mem_q[wr_word[IDX_W-1:0]][8*b +: 8] <= w_i.data[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ar_fire) begin
            r_rsp_q.data <= rd_in_range ? mem_q[rd_word[IDX_W-1:0]] : '0;
            r_rsp_q.resp <= rd_in_range ? mem_pkg::RESP_OKAY : mem_pkg::RESP_SLVERR;
        end
        if (wr_fire) begin
            b_rsp_q.resp <= wr_in_range ? mem_pkg::RESP_OKAY : mem_pkg::RESP_SLVERR;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            r_valid_q <= 1'b0;
            b_valid_q <= 1'b0;
        end else begin
            if (ar_fire) begin
                r_valid_q <= 1'b1;
            end else if (r_ready_i) begin
                r_valid_q <= 1'b0;
            end
            if (wr_fire) begin
                b_valid_q <= 1'b1;
            end else if (b_ready_i) begin
                b_valid_q <= 1'b0;
            end
        end
    end

    assign r_valid_o = r_valid_q;
    assign r_o       = r_rsp_q;
    assign b_valid_o = b_valid_q;
    assign b_o       = b_rsp_q;

    // Pending write response holds until taken
    a_b_held: assert property (@(posedge clk) disable iff (rst)
        b_valid_o && !b_ready_i |=> b_valid_o && $stable(b_o));

endmodule

//--- hdl/mem_subsys_top.sv
`timescale 1ns/1ps

module mem_subsys_top #(
    parameter int MEM_WORDS = 256
) (
    input  logic                             clk,
    input  logic                             rst,

    input  logic                             f_ar_valid_i,
    output logic                             f_ar_ready_o,
    input  logic [mem_pkg::FETCH_ADDR_W-1:0] f_ar_addr_i,
    output logic                             f_r_valid_o,
    input  logic                             f_r_ready_i,
    output mem_pkg::r_rsp_t                  f_r_o,

    input  logic                             l_ar_valid_i,
    output logic                             l_ar_ready_o,
    input  mem_pkg::ar_req_t                 l_ar_i,
    input  logic                             l_aw_valid_i,
    output logic                             l_aw_ready_o,
    input  mem_pkg::aw_req_t                 l_aw_i,
    input  logic                             l_w_valid_i,
    output logic                             l_w_ready_o,
    input  mem_pkg::w_req_t                  l_w_i,
    output logic                             l_r_valid_o,
    input  logic                             l_r_ready_i,
    output mem_pkg::r_rsp_t                  l_r_o,
    output logic                             l_b_valid_o,
    input  logic                             l_b_ready_i,
    output mem_pkg::b_rsp_t                  l_b_o
);

    // Arbiter side of the channel registers
    logic             m_ar_valid, m_ar_ready;
    mem_pkg::ar_req_t m_ar;
    logic             m_aw_valid, m_aw_ready;
    mem_pkg::aw_req_t m_aw;
    logic             m_w_valid, m_w_ready;
    mem_pkg::w_req_t  m_w;

    // SRAM side
    logic             s_ar_valid, s_ar_ready;
    mem_pkg::ar_req_t s_ar;
    logic             s_aw_valid, s_aw_ready;
    mem_pkg::aw_req_t s_aw;
    logic             s_w_valid, s_w_ready;
    mem_pkg::w_req_t  s_w;
    logic             s_r_valid, s_r_ready;
    mem_pkg::r_rsp_t  s_r;
    logic             s_b_valid, s_b_ready;
    mem_pkg::b_rsp_t  s_b;

    axi_arbiter u_arbiter (
        .clk          (clk),          .rst          (rst),
        .f_ar_valid_i (f_ar_valid_i), .f_ar_ready_o (f_ar_ready_o), .f_ar_addr_i (f_ar_addr_i),
        .f_r_valid_o  (f_r_valid_o),  .f_r_ready_i  (f_r_ready_i),  .f_r_o       (f_r_o),
        .l_ar_valid_i (l_ar_valid_i), .l_ar_ready_o (l_ar_ready_o), .l_ar_i      (l_ar_i),
        .l_aw_valid_i (l_aw_valid_i), .l_aw_ready_o (l_aw_ready_o), .l_aw_i      (l_aw_i),
        .l_w_valid_i  (l_w_valid_i),  .l_w_ready_o  (l_w_ready_o),  .l_w_i       (l_w_i),
        .l_r_valid_o  (l_r_valid_o),  .l_r_ready_i  (l_r_ready_i),  .l_r_o       (l_r_o),
        .l_b_valid_o  (l_b_valid_o),  .l_b_ready_i  (l_b_ready_i),  .l_b_o       (l_b_o),
        .m_ar_valid_o (m_ar_valid),   .m_ar_ready_i (m_ar_ready),   .m_ar_o      (m_ar),
        .m_aw_valid_o (m_aw_valid),   .m_aw_ready_i (m_aw_ready),   .m_aw_o      (m_aw),
        .m_w_valid_o  (m_w_valid),    .m_w_ready_i  (m_w_ready),    .m_w_o       (m_w),
        .m_r_valid_i  (s_r_valid),    .m_r_ready_o  (s_r_ready),    .m_r_i       (s_r),
        .m_b_valid_i  (s_b_valid),    .m_b_ready_o  (s_b_ready),    .m_b_i       (s_b)
    );

    axi_chan_reg #(.payload_t(mem_pkg::ar_req_t)) u_ar_reg (
        .clk (clk), .rst (rst),
        .in_valid_i  (m_ar_valid), .in_ready_o  (m_ar_ready), .in_data_i  (m_ar),
        .out_valid_o (s_ar_valid), .out_ready_i (s_ar_ready), .out_data_o (s_ar)
    );

    axi_chan_reg #(.payload_t(mem_pkg::aw_req_t)) u_aw_reg (
        .clk (clk), .rst (rst),
        .in_valid_i  (m_aw_valid), .in_ready_o  (m_aw_ready), .in_data_i  (m_aw),
        .out_valid_o (s_aw_valid), .out_ready_i (s_aw_ready), .out_data_o (s_aw)
    );

    axi_chan_reg #(.payload_t(mem_pkg::w_req_t)) u_w_reg (
        .clk (clk), .rst (rst),
        .in_valid_i  (m_w_valid), .in_ready_o  (m_w_ready), .in_data_i  (m_w),
        .out_valid_o (s_w_valid), .out_ready_i (s_w_ready), .out_data_o (s_w)
    );

    axi_sram #(.MEM_WORDS(MEM_WORDS)) u_sram (
        .clk (clk), .rst (rst),
        .ar_valid_i (s_ar_valid), .ar_ready_o (s_ar_ready), .ar_i (s_ar),
        .aw_valid_i (s_aw_valid), .aw_ready_o (s_aw_ready), .aw_i (s_aw),
        .w_valid_i  (s_w_valid),  .w_ready_o  (s_w_ready),  .w_i  (s_w),
        .r_valid_o  (s_r_valid),  .r_ready_i  (s_r_ready),  .r_o  (s_r),
        .b_valid_o  (s_b_valid),  .b_ready_i  (s_b_ready),  .b_o  (s_b)
    );

endmodule

//--- bench/tb_mem_subsys.sv
`timescale 1ns/1ps

module tb_mem_subsys;

    localparam int MEM_WORDS = 256;
    localparam int TIMEOUT   = 50;

    logic                             clk;
    logic                             rst;
    logic                             f_ar_valid_i, f_ar_ready_o;
    logic [mem_pkg::FETCH_ADDR_W-1:0] f_ar_addr_i;
    logic                             f_r_valid_o, f_r_ready_i;
    mem_pkg::r_rsp_t                  f_r_o;
    logic                             l_ar_valid_i, l_ar_ready_o;
    mem_pkg::ar_req_t                 l_ar_i;
    logic                             l_aw_valid_i, l_aw_ready_o;
    mem_pkg::aw_req_t                 l_aw_i;
    logic                             l_w_valid_i, l_w_ready_o;
    mem_pkg::w_req_t                  l_w_i;
    logic                             l_r_valid_o, l_r_ready_i;
    mem_pkg::r_rsp_t                  l_r_o;
    logic                             l_b_valid_o, l_b_ready_i;
    mem_pkg::b_rsp_t                  l_b_o;

    // Outputs as the DUT sees them at the coming rising edge
    logic            s_f_ar_ready, s_l_ar_ready, s_l_aw_ready, s_l_w_ready;
    logic            s_f_r_valid, s_l_r_valid, s_l_b_valid;
    mem_pkg::r_rsp_t s_f_r, s_l_r;
    mem_pkg::b_rsp_t s_l_b;

    logic [mem_pkg::DATA_W-1:0] ref_mem [MEM_WORDS];
    logic [15:0]                lfsr_q;

    mem_subsys_top #(.MEM_WORDS(MEM_WORDS)) dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_hex(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp) else
            abort_run($sformatf("ERROR: %s = %h, expected %h", name, got, exp));
    endtask

    // Galois LFSR, one step per bit
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v      = {v[62:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
        end
        return v;
    endfunction

    function automatic logic addr_ok(input logic [63:0] addr);
        return (addr >> 3) < MEM_WORDS;
    endfunction

    function automatic logic [63:0] model_data(input logic [63:0] addr);
        return addr_ok(addr) ? ref_mem[addr >> 3] : '0;
    endfunction

    function automatic logic [1:0] model_resp(input logic [63:0] addr);
        return addr_ok(addr) ? mem_pkg::RESP_OKAY : mem_pkg::RESP_SLVERR;
    endfunction

    task automatic check_rsp(input string port, input mem_pkg::r_rsp_t rsp,
                             input logic [63:0] addr);
        check_hex({port, ".data"}, rsp.data, model_data(addr));
        check_hex({port, ".resp"}, rsp.resp, model_resp(addr));
    endtask

    // Sample just before the rising edge, return on the falling edge after it
    task automatic wait_cycle(inout int n, input string what);
        #1;
        s_f_ar_ready = f_ar_ready_o;
        s_l_ar_ready = l_ar_ready_o;
        s_l_aw_ready = l_aw_ready_o;
        s_l_w_ready  = l_w_ready_o;
        s_f_r_valid  = f_r_valid_o;
        s_l_r_valid  = l_r_valid_o;
        s_l_b_valid  = l_b_valid_o;
        s_f_r        = f_r_o;
        s_l_r        = l_r_o;
        s_l_b        = l_b_o;
        @(negedge clk);
        n++;
        if (n > TIMEOUT) begin
            abort_run({"Timeout: ", what, " never completed"});
        end
    endtask

    task automatic lsu_write(input logic [63:0] addr, input logic [63:0] data,
                             input logic [7:0] strb);
        int n;
        n            = 0;
        l_aw_valid_i = 1'b1;
        l_aw_i.addr  = addr;
        l_w_valid_i  = 1'b1;
        l_w_i.data   = data;
        l_w_i.strb   = strb;
        while (l_aw_valid_i || l_w_valid_i) begin
            wait_cycle(n, "load/store AW/W handshake");
            if (s_l_aw_ready)
                l_aw_valid_i = 1'b0;
            if (s_l_w_ready)
                l_w_valid_i = 1'b0;
        end
        l_b_ready_i = 1'b1;
        n = 0;
        do wait_cycle(n, "load/store B handshake"); while (!s_l_b_valid);
        l_b_ready_i = 1'b0;
        check_hex("l_b_o.resp", s_l_b.resp, model_resp(addr));
        if (addr_ok(addr)) begin
            for (int b = 0; b < 8; b++) begin
                if (strb[b])
                    ref_mem[addr >> 3][8*b +: 8] = data[8*b +: 8];
            end
        end
    endtask

    task automatic read_word(input logic fetch, input logic [63:0] addr);
        int n;
        n = 0;
        if (fetch) begin
            f_ar_valid_i = 1'b1;
            f_ar_addr_i  = addr[31:0];
        end else begin
            l_ar_valid_i = 1'b1;
            l_ar_i.addr  = addr;
        end
        while (f_ar_valid_i || l_ar_valid_i) begin
            wait_cycle(n, fetch ? "fetch AR handshake" : "load/store AR handshake");
            if (s_f_ar_ready)
                f_ar_valid_i = 1'b0;
            if (s_l_ar_ready)
                l_ar_valid_i = 1'b0;
        end
        f_r_ready_i = fetch;
        l_r_ready_i = !fetch;
        n = 0;
        do wait_cycle(n, "R handshake"); while (!(fetch ? s_f_r_valid : s_l_r_valid));
        f_r_ready_i = 1'b0;
        l_r_ready_i = 1'b0;
        check_rsp(fetch ? "f_r_o" : "l_r_o", fetch ? s_f_r : s_l_r, addr);
    endtask

    // Both ports ask in the same cycle, load/store may stall its response
    task automatic dual_read(input logic [63:0] l_addr, input logic [31:0] f_addr,
                             input int hold);
        int              n;
        int              held;
        logic            l_done;
        logic            f_done;
        logic            seen;
        mem_pkg::r_rsp_t first;
        n            = 0;
        held         = 0;
        l_done       = 1'b0;
        f_done       = 1'b0;
        seen         = 1'b0;
        l_ar_valid_i = 1'b1;
        l_ar_i.addr  = l_addr;
        f_ar_valid_i = 1'b1;
        f_ar_addr_i  = f_addr;
        f_r_ready_i  = 1'b1;
        l_r_ready_i  = (hold == 0);
        while (!(l_done && f_done)) begin
            wait_cycle(n, l_done ? "fetch read" : "load/store read");
            if (s_l_ar_ready)
                l_ar_valid_i = 1'b0;
            if (s_f_ar_ready)
                f_ar_valid_i = 1'b0;
            if (!l_done) begin
                assert (!s_f_r_valid && !s_f_ar_ready) else
                    abort_run("Fetch read was served before the load/store response");
            end
            if (s_l_r_valid) begin
                if (!seen)
                    first = s_l_r;
                seen = 1'b1;
                check_hex("l_r_o.data", s_l_r.data, first.data);
                check_hex("l_r_o.resp", s_l_r.resp, first.resp);
                if (l_r_ready_i) begin
                    l_done = 1'b1;
                    check_rsp("l_r_o", s_l_r, l_addr);
                end else begin
                    held++;
                    if (held >= hold)
                        l_r_ready_i = 1'b1;
                end
            end
            if (s_f_r_valid) begin
                f_done = 1'b1;
                check_rsp("f_r_o", s_f_r, f_addr);
            end
        end
        f_r_ready_i = 1'b0;
        l_r_ready_i = 1'b0;
    endtask

    task automatic check_reset_state();
        check_hex("f_r_valid_o", f_r_valid_o, 0);
        check_hex("l_r_valid_o", l_r_valid_o, 0);
        check_hex("l_b_valid_o", l_b_valid_o, 0);
        read_word(1'b0, 100 * 8);
    endtask

    task automatic write_then_fetch();
        logic [63:0] idx [4] = '{3, 17, 64, 200};
        foreach (idx[i]) begin
            lsu_write(idx[i] * 8, rand_bits(64), 8'hff);
        end
        foreach (idx[i]) begin
            read_word(1'b1, idx[i] * 8);
        end
    endtask

    task automatic strobe_merge();
        logic [63:0] data;
        logic [7:0]  strb;
        data = rand_bits(64);
        strb = 8'(rand_bits(8));
        lsu_write(17 * 8, data, strb);
        read_word(1'b0, 17 * 8);
    endtask

    task automatic read_backpressure();
        int hold;
        hold = 2 + int'(rand_bits(3));
        dual_read(200 * 8, 17 * 8, hold);
    endtask

    task automatic out_of_range();
        lsu_write(MEM_WORDS * 8, rand_bits(64), 8'hff);
        // Low index bits alias word 3
        lsu_write(64'h1_0000_0018, rand_bits(64), 8'hff);
        read_word(1'b0, (MEM_WORDS + 1) * 8);
        read_word(1'b1, (MEM_WORDS + 2) * 8);
        read_word(1'b0, 3 * 8);
    endtask

    initial begin
        rst          = 1'b1;
        lfsr_q       = 16'd25692;
        f_ar_valid_i = 1'b0;
        f_ar_addr_i  = '0;
        f_r_ready_i  = 1'b0;
        l_ar_valid_i = 1'b0;
        l_ar_i       = '0;
        l_aw_valid_i = 1'b0;
        l_aw_i       = '0;
        l_w_valid_i  = 1'b0;
        l_w_i        = '0;
        l_r_ready_i  = 1'b0;
        l_b_ready_i  = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = '0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_reset_state();
        write_then_fetch();
        strobe_merge();
        dual_read(3 * 8, 64 * 8, 0);
        read_backpressure();
        out_of_range();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- build.f
common/mem_pkg.sv
hdl/axi_chan_reg.sv
arbiter/axi_arbiter.sv
sram/axi_sram.sv
hdl/mem_subsys_top.sv
bench/tb_mem_subsys.sv

//--- Bender.yml
package:
  name: mem_subsys

sources:
  - files:
      - common/mem_pkg.sv
      - hdl/axi_chan_reg.sv
      - arbiter/axi_arbiter.sv
      - sram/axi_sram.sv
      - hdl/mem_subsys_top.sv
  - target: test
    files:
      - bench/tb_mem_subsys.sv
